/* rtl/io_pkg.sv */
package io_pkg;

  typedef logic [15:0] io_word_t;  // Bus data and address word
  typedef logic [7:0]  port_t;     // One GPIO port
  typedef logic [7:0]  irq_byte_t;

  // Number of port-select bits in the address
  localparam int MAX_PORTS = 3;

  // Register select bits, combined with a port-select bit
  localparam int REG_IN_BIT  = 0;
  localparam int REG_OUT_BIT = 1;
  localparam int REG_DIR_BIT = 2;
  localparam int REG_IFG_BIT = 4;
  localparam int REG_IES_BIT = 5;
  localparam int REG_IE_BIT  = 6;

  localparam int MISC_BIT      = 3;
  localparam int PORT_SEL_BASE = 8;   // Port n at bit 8+n
  localparam int TICKS_BIT     = 14;
  localparam int IRQ_BIT       = 15;

  // Under IRQ_BIT
  localparam int IRQ_CAUSE_BIT  = 0;
  localparam int IRQ_ENABLE_BIT = 1;

  // Volatile causes enabled by default, sticky ones off
  localparam io_word_t IRQ_ENABLE_RESET = 16'hFF00;

  // Volatile cause positions
  localparam int PORT_VOLATILE_BASE = 0;  // Ports 0..2
  localparam int TICKS_VOLATILE_POS = 4;

  // Sticky cause positions
  localparam int TICKS_STICKY_POS = 0;

endpackage

/* rtl/pin_sync.sv */
`timescale 1ns/1ps

module pin_sync #(
  parameter int num_ports = 3
) (
  input  logic                          clk,
  input  logic                          reset_button,
  input  io_pkg::port_t [num_ports-1:0] pins_in,
  output io_pkg::port_t [num_ports-1:0] synced,
  output io_pkg::port_t [num_ports-1:0] rise,
  output io_pkg::port_t [num_ports-1:0] fall
);
  import io_pkg::*;

  port_t [num_ports-1:0] meta;     // First stage, may be metastable
  port_t [num_ports-1:0] delayed;  // Synced value one cycle ago

  always_ff @(posedge clk) begin
    if (reset_button) begin
      meta    <= '0;
      synced  <= '0;
      delayed <= '0;
    end else begin
      meta    <= pins_in;
      synced  <= meta;
      delayed <= synced;
    end
  end

  // Edge detection on the synchronised pins
  assign rise = synced & ~delayed;
  assign fall = ~synced & delayed;

endmodule

/* rtl/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port (
  input  logic             clk,
  input  logic             reset_button,
  input  logic             wr,        // Already qualified by port select
  input  io_pkg::io_word_t reg_sel,
  input  io_pkg::port_t    wdata,
  input  io_pkg::port_t    rise,
  input  io_pkg::port_t    fall,
  output io_pkg::port_t    out,
  output io_pkg::port_t    dir,       // 1 output, 0 input
  output io_pkg::port_t    ifg,
  output io_pkg::port_t    ies,       // 1 falling, 0 rising
  output io_pkg::port_t    ie,
  output logic             port_irq
);
  import io_pkg::*;

  port_t ifg_set;

  // Edges picked by the edge-select bits
  assign ifg_set = (ies & fall) | (~ies & rise);

  always_ff @(posedge clk) begin
    if (reset_button) begin
      out <= '0;
      dir <= '0;
      ifg <= '0;
      ies <= '0;
      ie  <= '0;
    end else begin
      if (wr && reg_sel[REG_OUT_BIT]) begin
        out <= wdata;
      end
      if (wr && reg_sel[REG_DIR_BIT]) begin
        dir <= wdata;
      end
      if (wr && reg_sel[REG_IES_BIT]) begin
        ies <= wdata;
      end
      if (wr && reg_sel[REG_IE_BIT]) begin
        ie <= wdata;
      end

      // New edges are never lost, even during a flag write
      if (wr && reg_sel[REG_IFG_BIT]) begin
        ifg <= wdata | ifg_set;
      end else begin
        ifg <= ifg | ifg_set;
      end
    end
  end

  assign port_irq = |(ie & ifg);

endmodule

/* rtl/system_regs.sv */
`timescale 1ns/1ps

module system_regs (
  input  logic             clk,
  input  logic             reset_button,
  input  logic             io_wr,
  input  io_pkg::io_word_t io_addr,
  input  io_pkg::io_word_t io_dout,
  output io_pkg::io_word_t ticks,
  output logic [4:0]       misc_out,       // {leds, pio}
  output logic             ticks_overflow
);
  import io_pkg::*;

  logic ticks_load;
  logic misc_wr;

  assign ticks_load = io_wr & io_addr[TICKS_BIT];
  assign misc_wr    = io_wr & io_addr[MISC_BIT];

  // Free-running counter, a write loads it
  always_ff @(posedge clk) begin
    if (reset_button) begin
      ticks <= '0;
    end else if (ticks_load) begin
      ticks <= io_dout;
    end else begin
      ticks <= ticks + 16'd1;
    end
  end

  // High in the cycle that wraps FFFF to 0000
  assign ticks_overflow = (ticks == 16'hFFFF) & ~ticks_load;

  always_ff @(posedge clk) begin
    if (reset_button) begin
      misc_out <= '0;
    end else if (misc_wr) begin
      misc_out <= io_dout[4:0];
    end
  end

endmodule

/* rtl/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller (
  input  logic                         clk,
  input  logic                         reset_button,
  input  logic                         io_wr,
  input  io_pkg::io_word_t             io_addr,
  input  io_pkg::io_word_t             io_dout,
  input  logic [io_pkg::MAX_PORTS-1:0] port_irq,
  input  logic                         ticks_overflow,
  output io_pkg::irq_byte_t            volatile_irqs,
  output io_pkg::irq_byte_t            sticky_irqs,
  output io_pkg::io_word_t             irq_enable,
  output logic                         interrupt
);
  import io_pkg::*;

  irq_byte_t set_sticky;
  logic      cause_wr;
  logic      enable_wr;

  assign cause_wr  = io_wr & io_addr[IRQ_BIT] & io_addr[IRQ_CAUSE_BIT];
  assign enable_wr = io_wr & io_addr[IRQ_BIT] & io_addr[IRQ_ENABLE_BIT];

  // Volatile causes follow their sources directly
  always_comb begin
    volatile_irqs = '0;
    volatile_irqs[PORT_VOLATILE_BASE +: MAX_PORTS] = port_irq;
    volatile_irqs[TICKS_VOLATILE_POS] = ticks_overflow;
  end

  // One-shot events that must be held until cleared
  always_comb begin
    set_sticky = '0;
    set_sticky[TICKS_STICKY_POS] = ticks_overflow;
  end

  always_ff @(posedge clk) begin
    if (reset_button) begin
      sticky_irqs <= '0;
      irq_enable  <= IRQ_ENABLE_RESET;
      interrupt   <= 1'b0;
    end else begin
      if (cause_wr) begin
        sticky_irqs <= (sticky_irqs & ~io_dout[7:0]) | set_sticky;  // Write 1 to clear
      end else begin
        sticky_irqs <= sticky_irqs | set_sticky;
      end
      if (enable_wr) begin
        irq_enable <= io_dout;
      end
      // Upper enable byte gates volatile causes, lower byte sticky ones
      interrupt <= (|(volatile_irqs & irq_enable[15:8])) |
                   (|(sticky_irqs & irq_enable[7:0]));
    end
  end

endmodule

/* rtl/io_read_mux.sv */
`timescale 1ns/1ps

module io_read_mux #(
  parameter int num_ports = 3
) (
  input  io_pkg::io_word_t              io_addr,
  input  io_pkg::port_t [num_ports-1:0] synced,
  input  io_pkg::port_t [num_ports-1:0] out,
  input  io_pkg::port_t [num_ports-1:0] dir,
  input  io_pkg::port_t [num_ports-1:0] ifg,
  input  io_pkg::port_t [num_ports-1:0] ies,
  input  io_pkg::port_t [num_ports-1:0] ie,
  input  logic [4:0]                    misc_out,
  input  io_pkg::io_word_t              ticks,
  input  io_pkg::irq_byte_t             volatile_irqs,
  input  io_pkg::irq_byte_t             sticky_irqs,
  input  io_pkg::io_word_t              irq_enable,
  output io_pkg::io_word_t              io_din
);
  import io_pkg::*;

  // Address bits are one-hot selects, so overlapping reads OR together
  always_comb begin
    io_din = '0;

    for (int n = 0; n < num_ports; n++) begin
      if (io_addr[PORT_SEL_BASE + n]) begin
        if (io_addr[REG_IN_BIT])  io_din |= {8'd0, synced[n]};
        if (io_addr[REG_OUT_BIT]) io_din |= {8'd0, out[n]};
        if (io_addr[REG_DIR_BIT]) io_din |= {8'd0, dir[n]};
        if (io_addr[REG_IFG_BIT]) io_din |= {8'd0, ifg[n]};
        if (io_addr[REG_IES_BIT]) io_din |= {8'd0, ies[n]};
        if (io_addr[REG_IE_BIT])  io_din |= {8'd0, ie[n]};
      end
    end

    if (io_addr[MISC_BIT]) begin
      io_din |= {11'd0, misc_out};
    end
    if (io_addr[TICKS_BIT]) begin
      io_din |= ticks;
    end

    if (io_addr[IRQ_BIT] && io_addr[IRQ_CAUSE_BIT]) begin
      io_din |= {volatile_irqs, sticky_irqs};  // Cause word
    end
    if (io_addr[IRQ_BIT] && io_addr[IRQ_ENABLE_BIT]) begin
      io_din |= irq_enable;
    end
  end

endmodule

/* rtl/io_top.sv */
`timescale 1ns/1ps

module io_top #(
  parameter int num_ports = 3  // 1 to 3
) (
  input  logic                          clk,
  input  logic                          reset_button,
  input  logic                          io_wr,
  input  io_pkg::io_word_t              io_addr,
  input  io_pkg::io_word_t              io_dout,
  output io_pkg::io_word_t              io_din,
  input  io_pkg::port_t [num_ports-1:0] pins_in,
  output io_pkg::port_t [num_ports-1:0] pins_out,
  output io_pkg::port_t [num_ports-1:0] pins_dir,
  output logic [1:0]                    led_n,     // Active low
  output logic [2:0]                    pio,
  output logic                          interrupt
);
  import io_pkg::*;

  port_t [num_ports-1:0] synced;
  port_t [num_ports-1:0] rise;
  port_t [num_ports-1:0] fall;
  port_t [num_ports-1:0] out;
  port_t [num_ports-1:0] dir;
  port_t [num_ports-1:0] ifg;
  port_t [num_ports-1:0] ies;
  port_t [num_ports-1:0] ie;

  logic [MAX_PORTS-1:0] port_irq;
  io_word_t             ticks;
  logic [4:0]           misc_out;
  logic                 ticks_overflow;
  irq_byte_t            volatile_irqs;
  irq_byte_t            sticky_irqs;
  io_word_t             irq_enable;

  pin_sync #(.num_ports(num_ports)) u_pin_sync (
    .clk          (clk),
    .reset_button (reset_button),
    .pins_in      (pins_in),
    .synced       (synced),
    .rise         (rise),
    .fall         (fall)
  );

  for (genvar n = 0; n < MAX_PORTS; n++) begin : g_port
    if (n < num_ports) begin : g_used
      gpio_port u_gpio_port (
        .clk          (clk),
        .reset_button (reset_button),
        .wr           (io_wr & io_addr[PORT_SEL_BASE + n]),
        .reg_sel      (io_addr),
        .wdata        (io_dout[7:0]),
        .rise         (rise[n]),
        .fall         (fall[n]),
        .out          (out[n]),
        .dir          (dir[n]),
        .ifg          (ifg[n]),
        .ies          (ies[n]),
        .ie           (ie[n]),
        .port_irq     (port_irq[n])
      );
    end else begin : g_absent
      assign port_irq[n] = 1'b0;  // No port fitted here
    end
  end

  assign pins_out = out;
  assign pins_dir = dir;

  system_regs u_system_regs (
    .clk            (clk),
    .reset_button   (reset_button),
    .io_wr          (io_wr),
    .io_addr        (io_addr),
    .io_dout        (io_dout),
    .ticks          (ticks),
    .misc_out       (misc_out),
    .ticks_overflow (ticks_overflow)
  );

  // Misc bits 4:3 drive the LEDs, 2:0 the general pins
  assign led_n = ~misc_out[4:3];
  assign pio   = misc_out[2:0];

  irq_controller u_irq_controller (
    .clk            (clk),
    .reset_button   (reset_button),
    .io_wr          (io_wr),
    .io_addr        (io_addr),
    .io_dout        (io_dout),
    .port_irq       (port_irq),
    .ticks_overflow (ticks_overflow),
    .volatile_irqs  (volatile_irqs),
    .sticky_irqs    (sticky_irqs),
    .irq_enable     (irq_enable),
    .interrupt      (interrupt)
  );

  io_read_mux #(.num_ports(num_ports)) u_io_read_mux (
    .io_addr       (io_addr),
    .synced        (synced),
    .out           (out),
    .dir           (dir),
    .ifg           (ifg),
    .ies           (ies),
    .ie            (ie),
    .misc_out      (misc_out),
    .ticks         (ticks),
    .volatile_irqs (volatile_irqs),
    .sticky_irqs   (sticky_irqs),
    .irq_enable    (irq_enable),
    .io_din        (io_din)
  );

endmodule

/* test/io_top_tb.sv */
`timescale 1ns/1ps

module io_top_tb;
  import io_pkg::*;

  localparam int NUM_PORTS  = 3;
  localparam int TICKS_WAIT = 65600;  // Longest wait for a random ticks load to wrap
  // Reset cycles and the budgets of the reset, gpio, edge, port irq, ticks and misc tests
  localparam int TEST_CYCLES     = 3 + 40 + 60 + 100 + 120 + 150 + 20;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + TICKS_WAIT + 1000;

  localparam io_word_t MISC_ADDR    = 16'h0008;
  localparam io_word_t TICKS_ADDR   = 16'h4000;
  localparam io_word_t CAUSE_ADDR   = 16'h8001;
  localparam io_word_t ENABLE_ADDR  = 16'h8002;
  localparam io_word_t ALL_OUT_ADDR = 16'h0702;  // OUT on ports 0..2
  localparam io_word_t ALL_IFG_ADDR = 16'h0710;  // IFG on ports 0..2

  logic                  clk = 1'b0;
  logic                  reset_button;
  logic                  io_wr;
  io_word_t              io_addr;
  io_word_t              io_dout;
  io_word_t              io_din;
  port_t [NUM_PORTS-1:0] pins_in;
  port_t [NUM_PORTS-1:0] pins_out;
  port_t [NUM_PORTS-1:0] pins_dir;
  logic [1:0]            led_n;
  logic [2:0]            pio;
  logic                  interrupt;

  logic [31:0] lfsr = 32'ha9ae_064a;
  string       cur_test;
  int          tests;
  int          checks;
  int          errors;
  int          test_start_errors;

  io_top #(.num_ports(NUM_PORTS)) DUT (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .io_din       (io_din),
    .pins_in      (pins_in),
    .pins_out     (pins_out),
    .pins_dir     (pins_dir),
    .led_n        (led_n),
    .pio          (pio),
    .interrupt    (interrupt)
  );

  always #50 clk = ~clk;

  // Galois LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Port select bit plus one register bit
  function automatic io_word_t port_addr(input int n, input int reg_bit);
    io_word_t a;
    a = '0;
    a[PORT_SEL_BASE + n] = 1'b1;
    a[reg_bit] = 1'b1;
    return a;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic bus_write(input io_word_t addr, input io_word_t data);
    @(negedge clk);
    io_wr   = 1'b1;
    io_addr = addr;
    io_dout = data;
    @(negedge clk);  // Taken at the rising edge in between
    io_wr   = 1'b0;
    io_addr = '0;
    io_dout = '0;
  endtask

  task automatic bus_read(input io_word_t addr, output io_word_t data);
    @(negedge clk);
    io_addr = addr;
    #10 data = io_din;  // Combinational read settles well before the next edge
  endtask

  task automatic drive_pins(input port_t [NUM_PORTS-1:0] value);
    @(negedge clk);
    pins_in = value;
  endtask

  task automatic check_word(input string what, input io_word_t expected, input io_word_t actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_port(input string what, input port_t expected, input port_t actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_interrupt(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (interrupt !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    if (interrupt !== level) begin
      $display("%s: interrupt did not go %s within %0d cycles", cur_test,
               level ? "high" : "low", limit);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_start_errors) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  task automatic test_reset();
    io_word_t d;
    int       n;
    begin_test("reset_values");
    bus_read(TICKS_ADDR, d);
    check_word("ticks", 16'h0001, d);  // One edge since reset went low
    for (n = 0; n < NUM_PORTS; n++) begin
      bus_read(port_addr(n, REG_OUT_BIT), d);
      check_word("out", '0, d);
      bus_read(port_addr(n, REG_DIR_BIT), d);
      check_word("dir", '0, d);
      bus_read(port_addr(n, REG_IFG_BIT), d);
      check_word("ifg", '0, d);
      bus_read(port_addr(n, REG_IE_BIT), d);
      check_word("ie", '0, d);
      check_port("pins_dir", '0, pins_dir[n]);
    end
    bus_read(ENABLE_ADDR, d);
    check_word("irq_enable", 16'hFF00, d);
    check_bit("interrupt", 1'b0, interrupt);
    end_test();
  endtask

  task automatic test_gpio_output();
    port_t    o;
    port_t    d;
    io_word_t rd;
    int       n;
    begin_test("gpio_output");
    for (n = 0; n < NUM_PORTS; n++) begin
      o = port_t'(rand_bits(8));
      d = port_t'(rand_bits(8));
      bus_write(port_addr(n, REG_OUT_BIT), {8'd0, o});
      bus_write(port_addr(n, REG_DIR_BIT), {8'd0, d});
      check_port("pins_out", o, pins_out[n]);
      check_port("pins_dir", d, pins_dir[n]);
      bus_read(port_addr(n, REG_OUT_BIT), rd);
      check_word("out readback", {8'd0, o}, rd);
      bus_read(port_addr(n, REG_DIR_BIT), rd);
      check_word("dir readback", {8'd0, d}, rd);
    end
    o = port_t'(rand_bits(8));
    bus_write(ALL_OUT_ADDR, {8'd0, o});  // All ports at once
    for (n = 0; n < NUM_PORTS; n++) begin
      check_port("pins_out shared write", o, pins_out[n]);
    end
    bus_read(ALL_OUT_ADDR, rd);
    check_word("shared readback", {8'd0, o}, rd);
    end_test();
  endtask

  task automatic test_input_edges();
    port_t [NUM_PORTS-1:0] base;
    port_t [NUM_PORTS-1:0] nw;
    port_t [NUM_PORTS-1:0] ies;
    port_t                 exp;
    io_word_t              rd;
    int                    n;
    begin_test("input_edges");
    for (n = 0; n < NUM_PORTS; n++) begin
      base[n] = port_t'(rand_bits(8));
      nw[n]   = port_t'(rand_bits(8));
      ies[n]  = port_t'(rand_bits(8));
    end
    drive_pins(base);
    idle(1);
    for (n = 0; n < NUM_PORTS; n++) begin
      bus_read(port_addr(n, REG_IN_BIT), rd);
      check_word("in", {8'd0, base[n]}, rd);
    end
    for (n = 0; n < NUM_PORTS; n++) begin
      bus_write(port_addr(n, REG_IES_BIT), {8'd0, ies[n]});
    end
    bus_write(ALL_IFG_ADDR, 16'h0000);  // Drop flags from the first change
    drive_pins(nw);
    idle(2);
    for (n = 0; n < NUM_PORTS; n++) begin
      // Falling edges where ies is 1, rising where it is 0
      exp = (ies[n] & base[n] & ~nw[n]) | (~ies[n] & ~base[n] & nw[n]);
      bus_read(port_addr(n, REG_IFG_BIT), rd);
      check_word("ifg", {8'd0, exp}, rd);
    end
    bus_write(ALL_IFG_ADDR, 16'h0000);
    for (n = 0; n < NUM_PORTS; n++) begin
      bus_read(port_addr(n, REG_IFG_BIT), rd);
      check_word("ifg cleared", '0, rd);
    end
    end_test();
  endtask

  task automatic test_port_irq();
    port_t [NUM_PORTS-1:0] cur;
    logic [2:0]            b;
    io_word_t              exp;
    io_word_t              rd;
    int                    n;
    begin_test("port_interrupt");
    bus_write(ENABLE_ADDR, 16'hFF00);
    for (n = 0; n < NUM_PORTS; n++) begin
      cur = pins_in;
      b   = 3'(rand_bits(3));
      bus_write(port_addr(n, REG_IES_BIT), {8'd0, cur[n]});  // Edge away from present level
      bus_write(port_addr(n, REG_IE_BIT), 16'h00FF);
      bus_write(port_addr(n, REG_IFG_BIT), 16'h0000);
      check_bit("interrupt idle", 1'b0, interrupt);
      cur[n][b] = ~cur[n][b];
      drive_pins(cur);
      wait_interrupt(1'b1, 4);
      exp = '0;
      exp[8 + n] = 1'b1;  // Volatile byte sits in the upper half
      bus_read(CAUSE_ADDR, rd);
      check_word("cause", exp, rd);
      bus_write(port_addr(n, REG_IFG_BIT), 16'h0000);
      wait_interrupt(1'b0, 3);
      bus_write(port_addr(n, REG_IE_BIT), 16'h0000);
    end
    end_test();
  endtask

  task automatic test_ticks();
    io_word_t v;
    io_word_t rd;
    int       k;
    begin_test("ticks_sticky");
    v = io_word_t'(rand_bits(16));
    k = int'(rand_bits(4));
    bus_write(TICKS_ADDR, v);
    idle(k);
    bus_read(TICKS_ADDR, rd);
    check_word("ticks", v + io_word_t'(k + 1), rd);  // One count per edge after the load
    bus_write(ENABLE_ADDR, 16'h0001);  // Sticky ticks cause only
    wait_interrupt(1'b1, TICKS_WAIT);
    bus_read(CAUSE_ADDR, rd);
    check_word("cause after wrap", 16'h0001, rd);
    bus_write(CAUSE_ADDR, 16'h0001);
    wait_interrupt(1'b0, 3);
    bus_read(CAUSE_ADDR, rd);
    check_word("cause cleared", 16'h0000, rd);
    bus_write(TICKS_ADDR, 16'hFFF0);
    wait_interrupt(1'b1, 20);
    bus_read(CAUSE_ADDR, rd);
    check_word("cause after FFF0", 16'h0001, rd);
    bus_write(CAUSE_ADDR, 16'h0001);
    wait_interrupt(1'b0, 3);
    bus_write(ENABLE_ADDR, 16'hFF00);
    end_test();
  endtask

  task automatic test_misc();
    logic [4:0] m;
    io_word_t   rd;
    begin_test("misc_register");
    repeat (2) begin
      m = 5'(rand_bits(5));
      bus_write(MISC_ADDR, {11'd0, m});
      check_port("pio", {5'd0, m[2:0]}, {5'd0, pio});
      check_bit("led_n[0]", ~m[3], led_n[0]);  // LEDs are active low
      check_bit("led_n[1]", ~m[4], led_n[1]);
      bus_read(MISC_ADDR, rd);
      check_word("misc readback", {11'd0, m}, rd);
    end
    end_test();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog expired after %0d cycles, a test did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    reset_button = 1'b1;
    io_wr        = 1'b0;
    io_addr      = '0;
    io_dout      = '0;
    pins_in      = '0;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    repeat (3) @(negedge clk);
    reset_button = 1'b0;

    test_reset();
    test_gpio_output();
    test_input_edges();
    test_port_irq();
    test_ticks();
    test_misc();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/io_pkg.sv
rtl/pin_sync.sv
rtl/gpio_port.sv
rtl/system_regs.sv
rtl/irq_controller.sv
rtl/io_read_mux.sv
rtl/io_top.sv
test/io_top_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module io_top_tb -o io_top_tb_sim \
  && ./obj_dir/io_top_tb_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
